// File: Makefile
SRC := $(filter-out +%,$(shell cat list.f))

obj_dir/VprocTb: list.f $(SRC) include/proc_settings.svh
	verilator --binary --timing --assert -f list.f --top-module procTb

run: obj_dir/VprocTb
	@out="$$(./obj_dir/VprocTb)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: include/proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

////////////////////////////////////////
// Word sizes
////////////////////////////////////////

// Data byte, bus address and program counter all share one width
`define DATA_W 8

////////////////////////////////////////
// Fixed addresses
////////////////////////////////////////

// Bus address held while no transfer is in flight
`define BUS_ADDR_IDLE 8'hFF

// Thread start vectors in ROM, one per interrupt line
`define IRQ_VEC_0 8'hFF
`define IRQ_VEC_1 8'hFE

// Interrupt lines
`define IRQ_N 2

// Watchdog cycles allowed per stimulus line
`define WDOG_FACTOR 200

`endif

// File: list.f
+incdir+include
verilog/procPkg.sv
verilog/alu.sv
verilog/progCounter.sv
verilog/dataPath.sv
verilog/procControl.sv
verilog/procTop.sv
testbench/procTop_chk.sv
testbench/procTb.sv

// File: testbench/procTb.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module procTb;

    ////////////////////////////////////////
    // DUT signals
    ////////////////////////////////////////

    logic               CLK;
    logic               RESET = 1'b1;
    logic [`DATA_W-1:0] busAddr;
    logic [`DATA_W-1:0] busDataOut;
    logic               busWe;
    logic [`DATA_W-1:0] busDataIn = '0;
    logic [`DATA_W-1:0] romAddress;
    logic [`DATA_W-1:0] romData = '0;
    logic [`IRQ_N-1:0]  irqRaise = '0;
    logic [`IRQ_N-1:0]  irqAck;

    // Memory images
    logic [`DATA_W-1:0] rom [0:255];
    logic [`DATA_W-1:0] ram [0:255];

    // Expected writes in order and the interrupt schedule
    logic [`DATA_W-1:0] expAddr [$];
    logic [`DATA_W-1:0] expData [$];
    int                 irqLine [$];
    int                 irqCycle [$];

    int   lineCount = 0;
    int   errorCount = 0;
    int   checkCount = 0;
    int   writeIdx = 0;
    int   cycle = 0;
    int   ackCount [`IRQ_N];
    logic stimLoaded = 1'b0;

    procTop procTop_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .busAddr    (busAddr),
        .busDataOut (busDataOut),
        .busWe      (busWe),
        .busDataIn  (busDataIn),
        .romAddress (romAddress),
        .romData    (romData),
        .irqRaise   (irqRaise),
        .irqAck     (irqAck)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic checkValue(input int actual, input int expected, input string what);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Fills both memories and then applies the tagged lines of the stimulus file
    task automatic loadStimulus();
        int                fd;
        int                n;
        int                addr;
        int                value;
        logic [8*16-1:0]   tag;
        logic [8*128-1:0]  restOfLine;
        for (int i = 0; i < 256; i++) begin
            rom[i] = ~8'(i);
            ram[i] = 8'(i) ^ 8'h3C;
        end
        fd = $fopen("testbench/stimulus.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Cannot open the stimulus file testbench/stimulus.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    n = $fgets(restOfLine, fd);
                end else if (tag == "R") begin
                    // One row of sixteen ROM bytes
                    n = $fscanf(fd, "%h", addr);
                    for (int k = 0; k < 16; k++) begin
                        n = $fscanf(fd, "%h", value);
                        rom[8'(addr + k)] = 8'(value);
                    end
                    lineCount++;
                end else if (tag == "M") begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    ram[8'(addr)] = 8'(value);
                    lineCount++;
                end else if (tag == "I") begin
                    n = $fscanf(fd, "%d %d", addr, value);
                    irqLine.push_back(addr);
                    irqCycle.push_back(value);
                    lineCount++;
                end else if (tag == "W") begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    expAddr.push_back(8'(addr));
                    expData.push_back(8'(value));
                    lineCount++;
                end else begin
                    errorCount++;
                    $display("Unknown tag %0s in the stimulus file", tag);
                    n = $fgets(restOfLine, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Memory and interrupt models
    ////////////////////////////////////////

    // Both memories answer one cycle after the address
    always @(posedge CLK) begin
        romData   <= rom[romAddress];
        busDataIn <= ram[busAddr];
        // RAM takes the write after the read of the same edge
        if (busWe) begin
            ram[busAddr] = busDataOut;
        end
    end

    // Lines rise on their scheduled cycle and fall once acked
    always @(posedge CLK) begin
        if (RESET) begin
            cycle <= 0;
            for (int i = 0; i < `IRQ_N; i++) begin
                ackCount[i] <= 0;
            end
        end else begin
            cycle <= cycle + 1;
            for (int k = 0; k < irqLine.size(); k++) begin
                if (irqCycle[k] == cycle) begin
                    irqRaise[irqLine[k]] <= 1'b1;
                end
            end
            for (int i = 0; i < `IRQ_N; i++) begin
                if (irqAck[i]) begin
                    irqRaise[i] <= 1'b0;
                    ackCount[i] <= ackCount[i] + 1;
                end
            end
        end
    end

    // Every bus write is matched against the next expected one
    always @(posedge CLK) begin
        if (!RESET && busWe) begin
            if (writeIdx < expAddr.size()) begin
                checkValue(int'(busAddr), int'(expAddr[writeIdx]),
                           $sformatf("address of write %0d", writeIdx));
                checkValue(int'(busDataOut), int'(expData[writeIdx]),
                           $sformatf("data of write %0d", writeIdx));
            end else begin
                errorCount++;
                $display("Unexpected bus write of %h to address %h", busDataOut, busAddr);
            end
            writeIdx++;
        end
    end

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        int limit;
        wait (stimLoaded);
        limit = (lineCount > 0 ? lineCount : 1) * `WDOG_FACTOR;
        repeat (limit) @(posedge CLK);
        $display("Timeout after %0d cycles with %0d of %0d bus writes seen",
                 limit, writeIdx, expAddr.size());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        loadStimulus();
        stimLoaded = 1'b1;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        wait (writeIdx == expAddr.size());
        // Quiet period so stray writes and acks still show up
        repeat (20) @(posedge CLK);
        checkValue(ackCount[0], 1, "acks on line 0");
        checkValue(ackCount[1], 1, "acks on line 1");
        checkValue(writeIdx, int'(expAddr.size()), "number of bus writes");
        $display("Checks: %0d, errors: %0d, writes: %0d of %0d",
                 checkCount, errorCount, writeIdx, expAddr.size());
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/procTop_chk.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module procTop_chk (
    input logic               CLK,
    input logic               RESET,
    input logic [`DATA_W-1:0] busAddr,
    input logic               busWe,
    input logic [`IRQ_N-1:0]  irqAck,
    input procPkg::state_t    state
);

    import procPkg::*;

    // Write enable is a single cycle pulse
    writePulse: assert property (@(posedge CLK) disable iff (RESET) busWe |=> !busWe)
        else $error("busWe high for two cycles running");

    // At most one line acked at a time
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(irqAck))
        else $error("irqAck has more than one bit set");

    // Outside reads, dereferences and writes the bus rests at the idle address
    addrIdle: assert property (@(posedge CLK) disable iff (RESET)
        (!busWe && !(state inside {stRead0, stRead1, stRead2, stDerefA, stDerefB, stDeref0}))
        |-> busAddr == `BUS_ADDR_IDLE)
        else $error("busAddr %h away from idle outside a transfer", busAddr);

endmodule

bind procTop procTop_chk procTop_chk_i (
    .CLK     (CLK),
    .RESET   (RESET),
    .busAddr (busAddr),
    .busWe   (busWe),
    .irqAck  (irqAck),
    .state   (procControl_i.state)
);

// File: testbench/stimulus.txt
# R: start address, then 16 ROM bytes (hex)
# M: RAM address, byte (hex)   I: line, cycle after reset (decimal)   W: address, data (hex)
# Program: copy, maths, branches, call, dereference, idle at 68, threads at 70 and 78
R 00 00 10 01 11 02 80 03 81 04 02 82 14 02 83 24 02
R 10 84 34 02 85 45 03 86 54 65 02 87 03 88 75 84 02
R 20 89 03 8A 96 29 02 A0 07 2B 02 A1 B6 31 02 A2 07
R 30 33 02 A3 54 96 3A 02 A4 07 3C 02 A5 A6 42 02 A6
R 40 07 44 02 A7 54 A6 4B 02 A8 07 4D 02 A9 B6 53 02
R 50 AA 07 55 02 AB 09 6A 02 C0 07 5D 02 EE 0F 00 12
R 60 0B 02 D0 01 13 0C 03 D1 08 0F 03 C1 0A 0F 0F 0F
R 70 02 E1 08 0F 0F 0F 0F 0F 03 E0 08 0F 0F 0F 0F 0F
R F0 0F 0F 0F 0F 0F 0F 0F 0F 0F 0F 0F 0F 0F 0F 70 78
# RAM: operands at 10 and 11, pointers at 12 and 13 to 20 and 21
M 10 3C
M 11 05
M 12 20
M 13 21
M 20 99
M 21 77
# Line 1 after the core is idle, line 0 after thread 1 is back in idle
I 1 250
I 0 400
# Copy of the preloaded operands
W 80 3C
W 81 05
# Add, sub, mul, shift left, shift right into B, inc A, inc B, dec A into B, dec B into A
W 82 41
W 83 3C
W 84 2C
W 85 58
W 86 2C
W 87 59
W 88 2D
W 89 57
W 8A 58
# Branch markers, eq not taken, lt taken, eq taken, gt not taken, gt taken, lt not taken
W A0 57
W A3 57
W A5 58
W A6 58
W A9 59
W AA 59
# Subroutine write, then the write after return
W C1 58
W C0 59
# Dereference through A, then through B
W D0 99
W D1 77
# Thread of line 1 from vector FE, thread of line 0 from vector FF
W E1 99
W E0 77

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module alu (
    input  logic [`DATA_W-1:0] regA,
    input  logic [`DATA_W-1:0] regB,
    input  procPkg::aluOp_t    op,
    output logic [`DATA_W-1:0] result
);

    import procPkg::*;

    always_comb begin
        case (op)
            // Arithmetic
            add:         result = regA + regB;
            sub:         result = regA - regB;
            // Low byte of the product only
            mul:         result = regA * regB;

            // Single bit shifts of A
            shiftLeftA:  result = regA << 1;
            shiftRightA: result = regA >> 1;

            // Increment and decrement
            incA:        result = regA + `DATA_W'(1);
            incB:        result = regB + `DATA_W'(1);
            decA:        result = regA - `DATA_W'(1);
            decB:        result = regB - `DATA_W'(1);

            // Compares give 1 or 0 for branch
            eq: begin
                result = (regA == regB) ? `DATA_W'(1) : '0;
            end
            gt: begin
                result = (regA > regB) ? `DATA_W'(1) : '0;
            end
            lt: begin
                result = (regA < regB) ? `DATA_W'(1) : '0;
            end

            // Anything else passes A
            default:     result = regA;
        endcase
    end

endmodule

// File: verilog/dataPath.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module dataPath (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               loadA,
    input  logic               loadB,
    input  logic               regSel,
    input  logic               loadFromAlu,
    input  logic               addrFromOperand,
    input  logic               addrFromReg,
    input  logic               writeBus,
    input  logic [`DATA_W-1:0] operand,
    input  logic [`DATA_W-1:0] busDataIn,
    output logic [`DATA_W-1:0] aluOut,
    output logic [`DATA_W-1:0] busAddr,
    output logic [`DATA_W-1:0] busDataOut,
    output logic               busWe
);

    import procPkg::*;

    romWord_t           word;
    logic [`DATA_W-1:0] regA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] selReg;
    logic [`DATA_W-1:0] loadData;

    // The ROM byte seen as an instruction picks the ALU op
    assign word = operand;

    alu alu_i (
        .regA   (regA),
        .regB   (regB),
        .op     (word.instr.aluOp),
        .result (aluOut)
    );

    // Register feeding bus address and write data
    assign selReg = regSel ? regB : regA;

    // Load from a bus read or from the ALU
    assign loadData = loadFromAlu ? aluOut : busDataIn;

    ////////////////////////////////////////
    // Working registers
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (loadA) begin
            regA <= loadData;
        end
        if (loadB) begin
            regB <= loadData;
        end
        if (writeBus) begin
            busDataOut <= selReg;
        end
    end

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= `BUS_ADDR_IDLE;
            busWe   <= 1'b0;
        end else begin
            // Address only holds for the cycle it was asked for
            if (addrFromOperand) begin
                busAddr <= operand;
            end else if (addrFromReg) begin
                busAddr <= selReg;
            end else begin
                busAddr <= `BUS_ADDR_IDLE;
            end
            // Write pulse lines up with its data
            busWe <= writeBus;
        end
    end

endmodule

// File: verilog/procControl.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module procControl (
    input  logic               CLK,
    input  logic               RESET,
    input  logic [`DATA_W-1:0] romData,
    input  logic [`DATA_W-1:0] aluOut,
    input  logic [`IRQ_N-1:0]  irqRaise,
    output logic               pcLoad,
    output procPkg::pcSrc_t    pcSrc,
    output logic               pcInc1,
    output logic               pcInc2,
    output logic               fetchOffset,
    output logic               saveContext,
    output logic               vectorSel,
    output logic               loadA,
    output logic               loadB,
    output logic               regSel,
    output logic               loadFromAlu,
    output logic               addrFromOperand,
    output logic               addrFromReg,
    output logic               writeBus,
    output logic [`IRQ_N-1:0]  irqAck
);

    import procPkg::*;

    romWord_t          word;
    state_t            state;
    state_t            stateNext;
    logic              selB;
    logic              selNext;
    logic [`IRQ_N-1:0] irqAckNext;

    assign word = romData;

    // New select is visible in the state that sets it
    assign regSel = selNext;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= stChooseOp;
            selB   <= 1'b0;
            irqAck <= '0;
        end else begin
            state  <= stateNext;
            selB   <= selNext;
            irqAck <= irqAckNext;
        end
    end

    ////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////

    always_comb begin
        stateNext       = state;
        selNext         = selB;
        irqAckNext      = '0;
        pcLoad          = 1'b0;
        pcSrc           = pcFromOperand;
        pcInc1          = 1'b0;
        pcInc2          = 1'b0;
        fetchOffset     = 1'b0;
        saveContext     = 1'b0;
        vectorSel       = 1'b0;
        loadA           = 1'b0;
        loadB           = 1'b0;
        loadFromAlu     = 1'b0;
        addrFromOperand = 1'b0;
        addrFromReg     = 1'b0;
        writeBus        = 1'b0;

        case (state)
            // Wait for an interrupt, line 0 first
            stIdle: begin
                if (irqRaise[0]) begin
                    stateNext     = stThread0;
                    pcLoad        = 1'b1;
                    pcSrc         = pcFromVector;
                    irqAckNext[0] = 1'b1;
                end else if (irqRaise[1]) begin
                    stateNext     = stThread0;
                    pcLoad        = 1'b1;
                    pcSrc         = pcFromVector;
                    vectorSel     = 1'b1;
                    irqAckNext[1] = 1'b1;
                end
            end
            // Vector byte on its way from ROM
            stThread0: stateNext = stThread1;
            stThread1: begin
                stateNext = stThread2;
                pcLoad    = 1'b1;
            end
            stThread2: stateNext = stChooseOp;

            // Decode, operand byte is fetched next
            stChooseOp: begin
                fetchOffset = 1'b1;
                case (word.instr.opcode)
                    readA:    stateNext = stReadToA;
                    readB:    stateNext = stReadToB;
                    writeA:   stateNext = stWriteFromA;
                    writeB:   stateNext = stWriteFromB;
                    mathsA:   stateNext = stMathsToA;
                    mathsB:   stateNext = stMathsToB;
                    branch:   stateNext = stBranch;
                    gotoAddr: stateNext = stGoto;
                    idle:     stateNext = stIdle;
                    call:     stateNext = stCall;
                    ret:      stateNext = stReturn;
                    derefA:   stateNext = stDerefA;
                    derefB:   stateNext = stDerefB;
                    // Undefined codes run as NOP
                    default:  stateNext = stNop;
                endcase
            end

            ////////////////////////////////////////
            // Memory read
            ////////////////////////////////////////

            stReadToA: begin
                stateNext = stRead0;
                selNext   = 1'b0;
            end
            stReadToB: begin
                stateNext = stRead0;
                selNext   = 1'b1;
            end
            // Operand byte is the bus address
            stRead0: begin
                stateNext       = stRead1;
                addrFromOperand = 1'b1;
            end
            stRead1: begin
                stateNext = stRead2;
                pcInc2    = 1'b1;
            end
            // RAM data is back, shared with dereference
            stRead2: begin
                stateNext = stChooseOp;
                loadA     = !selB;
                loadB     = selB;
            end

            ////////////////////////////////////////
            // Memory write
            ////////////////////////////////////////

            stWriteFromA: begin
                stateNext = stWrite0;
                selNext   = 1'b0;
                pcInc2    = 1'b1;
            end
            stWriteFromB: begin
                stateNext = stWrite0;
                selNext   = 1'b1;
                pcInc2    = 1'b1;
            end
            stWrite0: begin
                stateNext       = stChooseOp;
                addrFromOperand = 1'b1;
                writeBus        = 1'b1;
            end

            // ALU result into A or B
            stMathsToA: begin
                stateNext   = stMaths0;
                loadA       = 1'b1;
                loadFromAlu = 1'b1;
                pcInc1      = 1'b1;
            end
            stMathsToB: begin
                stateNext   = stMaths0;
                loadB       = 1'b1;
                loadFromAlu = 1'b1;
                pcInc1      = 1'b1;
            end
            stMaths0: stateNext = stChooseOp;

            ////////////////////////////////////////
            // Program flow
            ////////////////////////////////////////

            // Compare result still comes from the instruction byte
            stBranch: begin
                if (aluOut != '0) begin
                    stateNext = stBranch0;
                end else begin
                    stateNext = stBranch1;
                    pcInc2    = 1'b1;
                end
            end
            // Taken, jump then one wait state
            stBranch0: begin
                stateNext = stBranch1;
                pcLoad    = 1'b1;
            end
            stBranch1: stateNext = stChooseOp;

            stGoto: stateNext = stGoto0;
            stGoto0: begin
                stateNext = stGoto1;
                pcLoad    = 1'b1;
            end
            stGoto1: stateNext = stChooseOp;

            // Call is a goto that remembers where to come back
            stCall: begin
                stateNext   = stGoto0;
                saveContext = 1'b1;
            end
            stReturn: begin
                stateNext = stReturn0;
                pcLoad    = 1'b1;
                pcSrc     = pcFromContext;
            end
            stReturn0: stateNext = stChooseOp;

            // Pointer held in A or B
            stDerefA: begin
                stateNext   = stDeref0;
                selNext     = 1'b0;
                addrFromReg = 1'b1;
            end
            stDerefB: begin
                stateNext   = stDeref0;
                selNext     = 1'b1;
                addrFromReg = 1'b1;
            end
            stDeref0: begin
                stateNext = stRead2;
                pcInc1    = 1'b1;
            end

            stNop: begin
                stateNext = stNop0;
                pcInc1    = 1'b1;
            end
            stNop0: stateNext = stChooseOp;

            default: stateNext = stChooseOp;
        endcase
    end

endmodule

// File: verilog/procPkg.sv
`include "proc_settings.svh"

package procPkg;

    ////////////////////////////////////////
    // Instruction set
    ////////////////////////////////////////

    // Low nibble of an instruction byte
    typedef enum logic [3:0] {
        readA    = 4'h0,
        readB    = 4'h1,
        writeA   = 4'h2,
        writeB   = 4'h3,
        mathsA   = 4'h4,
        mathsB   = 4'h5,
        branch   = 4'h6,
        gotoAddr = 4'h7,
        idle     = 4'h8,
        call     = 4'h9,
        ret      = 4'hA,
        derefA   = 4'hB,
        derefB   = 4'hC,
        nop      = 4'hF
    } opcode_t;

    // High nibble of an instruction byte, unlisted codes pass A through
    typedef enum logic [3:0] {
        add         = 4'h0,
        sub         = 4'h1,
        mul         = 4'h2,
        shiftLeftA  = 4'h3,
        shiftRightA = 4'h4,
        incA        = 4'h5,
        incB        = 4'h6,
        decA        = 4'h7,
        decB        = 4'h8,
        eq          = 4'h9,
        gt          = 4'hA,
        lt          = 4'hB
    } aluOp_t;

    // A ROM byte is either an address operand or an instruction
    typedef union packed {
        logic [`DATA_W-1:0] addr;
        struct packed {
            aluOp_t  aluOp;
            opcode_t opcode;
        } instr;
    } romWord_t;

    // Program counter load source
    typedef enum logic [1:0] {
        pcFromOperand = 2'd0,
        pcFromContext = 2'd1,
        pcFromVector  = 2'd2
    } pcSrc_t;

    ////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////

    typedef enum logic [7:0] {
        stChooseOp   = 8'h00,
        stReadToA    = 8'h10,
        stReadToB    = 8'h11,
        stRead0      = 8'h12,
        stRead1      = 8'h13,
        stRead2      = 8'h14,
        stWriteFromA = 8'h20,
        stWriteFromB = 8'h21,
        stWrite0     = 8'h22,
        stMathsToA   = 8'h30,
        stMathsToB   = 8'h31,
        stMaths0     = 8'h32,
        stBranch     = 8'h40,
        stBranch0    = 8'h41,
        stBranch1    = 8'h42,
        stGoto       = 8'h50,
        stGoto0      = 8'h51,
        stGoto1      = 8'h52,
        stCall       = 8'h70,
        stReturn     = 8'h80,
        stReturn0    = 8'h81,
        stDerefA     = 8'h90,
        stDerefB     = 8'h91,
        stDeref0     = 8'h92,
        stNop        = 8'hA0,
        stNop0       = 8'hA1,
        stIdle       = 8'hF0,
        stThread0    = 8'hF1,
        stThread1    = 8'hF2,
        stThread2    = 8'hF3
    } state_t;

endpackage

// File: verilog/procTop.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module procTop (
    input  logic               CLK,
    input  logic               RESET,
    output logic [`DATA_W-1:0] busAddr,
    output logic [`DATA_W-1:0] busDataOut,
    output logic               busWe,
    input  logic [`DATA_W-1:0] busDataIn,
    output logic [`DATA_W-1:0] romAddress,
    input  logic [`DATA_W-1:0] romData,
    input  logic [`IRQ_N-1:0]  irqRaise,
    output logic [`IRQ_N-1:0]  irqAck
);

    import procPkg::*;

    // Program counter strobes
    logic   pcLoad;
    pcSrc_t pcSrc;
    logic   pcInc1;
    logic   pcInc2;
    logic   fetchOffset;
    logic   saveContext;
    logic   vectorSel;

    // Data path strobes
    logic               loadA;
    logic               loadB;
    logic               regSel;
    logic               loadFromAlu;
    logic               addrFromOperand;
    logic               addrFromReg;
    logic               writeBus;
    logic [`DATA_W-1:0] aluOut;

    procControl procControl_i (
        .CLK             (CLK),
        .RESET           (RESET),
        .romData         (romData),
        .aluOut          (aluOut),
        .irqRaise        (irqRaise),
        .pcLoad          (pcLoad),
        .pcSrc           (pcSrc),
        .pcInc1          (pcInc1),
        .pcInc2          (pcInc2),
        .fetchOffset     (fetchOffset),
        .saveContext     (saveContext),
        .vectorSel       (vectorSel),
        .loadA           (loadA),
        .loadB           (loadB),
        .regSel          (regSel),
        .loadFromAlu     (loadFromAlu),
        .addrFromOperand (addrFromOperand),
        .addrFromReg     (addrFromReg),
        .writeBus        (writeBus),
        .irqAck          (irqAck)
    );

    // ROM byte doubles as jump target
    progCounter progCounter_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .pcLoad      (pcLoad),
        .pcSrc       (pcSrc),
        .pcInc1      (pcInc1),
        .pcInc2      (pcInc2),
        .fetchOffset (fetchOffset),
        .saveContext (saveContext),
        .operand     (romData),
        .vectorSel   (vectorSel),
        .romAddress  (romAddress)
    );

    // ROM byte doubles as bus address and ALU op
    dataPath dataPath_i (
        .CLK             (CLK),
        .RESET           (RESET),
        .loadA           (loadA),
        .loadB           (loadB),
        .regSel          (regSel),
        .loadFromAlu     (loadFromAlu),
        .addrFromOperand (addrFromOperand),
        .addrFromReg     (addrFromReg),
        .writeBus        (writeBus),
        .operand         (romData),
        .busDataIn       (busDataIn),
        .aluOut          (aluOut),
        .busAddr         (busAddr),
        .busDataOut      (busDataOut),
        .busWe           (busWe)
    );

endmodule

// File: verilog/progCounter.sv
`timescale 1ns/1ps
`include "proc_settings.svh"

module progCounter (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               pcLoad,
    input  procPkg::pcSrc_t    pcSrc,
    input  logic               pcInc1,
    input  logic               pcInc2,
    input  logic               fetchOffset,
    input  logic               saveContext,
    input  logic [`DATA_W-1:0] operand,
    input  logic               vectorSel,
    output logic [`DATA_W-1:0] romAddress
);

    import procPkg::*;

    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] savedContext;
    logic [`DATA_W-1:0] loadValue;
    logic               offset;

    // Source of a counter load
    always_comb begin
        case (pcSrc)
            pcFromContext: loadValue = savedContext;
            pcFromVector:  loadValue = vectorSel ? `IRQ_VEC_1 : `IRQ_VEC_0;
            default:       loadValue = operand;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc           <= '0;
            offset       <= 1'b0;
            savedContext <= '0;
        end else begin
            // Load wins over increment
            if (pcLoad) begin
                pc <= loadValue;
            end else if (pcInc2) begin
                pc <= pc + `DATA_W'(2);
            end else if (pcInc1) begin
                pc <= pc + `DATA_W'(1);
            end

            // Offset points at the operand byte for one cycle only
            offset <= fetchOffset;

            // Return lands after the two-byte call
            if (saveContext) begin
                savedContext <= pc + `DATA_W'(2);
            end
        end
    end

    assign romAddress = pc + `DATA_W'(offset);

endmodule
